//--- Bender.yml
package:
  name: issue_stage

sources:
  - rtl/issue_pkg.sv
  - rtl/phys_reg_file.sv
  - rtl/reservation_station.sv
  - rtl/alu_unit.sv
  - rtl/load_store_unit.sv
  - rtl/cdb_arbiter.sv
  - rtl/issue_top.sv
  - target: test
    files:
      - testbench/issue_checker.sv
      - testbench/tb_issue.sv

//--- rtl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit import issue_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alu_issue,
    input  op_t                  iss_op,
    input  word_t                iss_a,
    input  word_t                iss_b,
    input  word_t                iss_imm,
    input  logic [TAG_WIDTH-1:0] iss_tag,
    input  logic                 grant,
    output logic                 res_valid,
    output logic [TAG_WIDTH-1:0] res_tag,
    output word_t                res_value,
    output logic                 busy
);

    word_t op_b;
    word_t result;

    assign op_b = (iss_op == op_addi) ? iss_imm : iss_b;

    always_comb begin
        case (iss_op)
            op_add, op_addi: result = iss_a + op_b;
            op_sub:          result = iss_a - op_b;
            op_and:          result = iss_a & op_b;
            op_or:           result = iss_a | op_b;
            op_xor:          result = iss_a ^ op_b;
            default:         result = '0;
        endcase
    end

    // Held result blocks the next issue until the bus takes it
    assign busy = res_valid && !grant;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (alu_issue) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            res_tag <= iss_tag;
            res_value <= result;
        end
    end

endmodule

//--- rtl/cdb_arbiter.sv
`timescale 1ns/10ps

module cdb_arbiter import issue_pkg::*; (
    input  logic                 alu_valid,
    input  logic [TAG_WIDTH-1:0] alu_tag,
    input  word_t                alu_value,
    input  logic                 lsu_valid,
    input  logic [TAG_WIDTH-1:0] lsu_tag,
    input  word_t                lsu_value,
    output logic                 alu_grant,
    output logic                 lsu_grant,
    output logic                 cdb_valid,
    output logic [TAG_WIDTH-1:0] cdb_tag,
    output word_t                cdb_value
);

    // Load/store unit always wins over the ALU
    assign lsu_grant = lsu_valid;
    assign alu_grant = alu_valid && !lsu_valid;

    assign cdb_valid = alu_valid || lsu_valid;
    assign cdb_tag   = lsu_grant ? lsu_tag : alu_tag;
    assign cdb_value = lsu_grant ? lsu_value : alu_value;

endmodule

//--- rtl/issue_pkg.sv
package issue_pkg;

    // Data path and tag sizes
    localparam int XLEN = 32;
    localparam int TAG_WIDTH = 5;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_and   = 3'd2,
        op_or    = 3'd3,
        op_xor   = 3'd4,
        op_addi  = 3'd5,
        op_load  = 3'd6,
        op_store = 3'd7
    } op_t;

    // Loads and stores go to the load/store unit
    function automatic logic is_mem_op(op_t op);
        return (op == op_load) || (op == op_store);
    endfunction

    // Immediate forms leave the second source unused
    function automatic logic uses_rs2(op_t op);
        return (op != op_addi) && (op != op_load);
    endfunction

    // Stores write memory only and free no tag
    function automatic logic writes_rd(op_t op);
        return op != op_store;
    endfunction

endpackage

//--- rtl/issue_top.sv
`timescale 1ns/10ps

module issue_top import issue_pkg::*; #(
    parameter int RS_DEPTH   = 4,
    parameter int PREG_COUNT = 32,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  op_t                  dispatch_op,
    input  logic [TAG_WIDTH-1:0] dispatch_rs1,
    input  logic [TAG_WIDTH-1:0] dispatch_rs2,
    input  logic [TAG_WIDTH-1:0] dispatch_rd,
    input  word_t                dispatch_imm,
    output logic                 rs_full,
    output logic                 cdb_valid,
    output logic [TAG_WIDTH-1:0] cdb_tag,
    output word_t                cdb_value
);

    // Operand read
    logic [TAG_WIDTH-1:0] rd_tag_a;
    logic [TAG_WIDTH-1:0] rd_tag_b;
    logic                 alloc_valid;
    logic [TAG_WIDTH-1:0] alloc_tag;
    word_t                val_a;
    word_t                val_b;
    logic                 rdy_a;
    logic                 rdy_b;

    // Issue
    logic                 alu_issue;
    logic                 lsu_issue;
    op_t                  iss_op;
    word_t                iss_a;
    word_t                iss_b;
    word_t                iss_imm;
    logic [TAG_WIDTH-1:0] iss_tag;

    // Unit results
    logic                 alu_valid;
    logic [TAG_WIDTH-1:0] alu_tag;
    word_t                alu_value;
    logic                 alu_grant;
    logic                 alu_busy;
    logic                 lsu_valid;
    logic [TAG_WIDTH-1:0] lsu_tag;
    word_t                lsu_value;
    logic                 lsu_grant;
    logic                 lsu_busy;

    phys_reg_file #(.PREG_COUNT(PREG_COUNT)) u_prf (
        .clk(clk), .reset(reset),
        .rd_tag_a(rd_tag_a), .rd_tag_b(rd_tag_b),
        .alloc_valid(alloc_valid), .alloc_tag(alloc_tag),
        .val_a(val_a), .val_b(val_b), .rdy_a(rdy_a), .rdy_b(rdy_b),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_rs1(dispatch_rs1), .dispatch_rs2(dispatch_rs2),
        .dispatch_rd(dispatch_rd), .dispatch_imm(dispatch_imm),
        .rs_full(rs_full),
        .rd_tag_a(rd_tag_a), .rd_tag_b(rd_tag_b),
        .alloc_valid(alloc_valid), .alloc_tag(alloc_tag),
        .val_a(val_a), .val_b(val_b), .rdy_a(rdy_a), .rdy_b(rdy_b),
        .alu_busy(alu_busy), .lsu_busy(lsu_busy),
        .alu_issue(alu_issue), .lsu_issue(lsu_issue),
        .iss_op(iss_op), .iss_a(iss_a), .iss_b(iss_b),
        .iss_imm(iss_imm), .iss_tag(iss_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    alu_unit u_alu (
        .clk(clk), .reset(reset),
        .alu_issue(alu_issue), .iss_op(iss_op), .iss_a(iss_a), .iss_b(iss_b),
        .iss_imm(iss_imm), .iss_tag(iss_tag), .grant(alu_grant),
        .res_valid(alu_valid), .res_tag(alu_tag), .res_value(alu_value),
        .busy(alu_busy)
    );

    load_store_unit #(.DMEM_DEPTH(DMEM_DEPTH)) u_lsu (
        .clk(clk), .reset(reset),
        .lsu_issue(lsu_issue), .iss_op(iss_op), .iss_a(iss_a), .iss_b(iss_b),
        .iss_imm(iss_imm), .iss_tag(iss_tag), .grant(lsu_grant),
        .res_valid(lsu_valid), .res_tag(lsu_tag), .res_value(lsu_value),
        .busy(lsu_busy)
    );

    cdb_arbiter u_arb (
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
        .lsu_valid(lsu_valid), .lsu_tag(lsu_tag), .lsu_value(lsu_value),
        .alu_grant(alu_grant), .lsu_grant(lsu_grant),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit import issue_pkg::*; #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 lsu_issue,
    input  op_t                  iss_op,
    input  word_t                iss_a,
    input  word_t                iss_b,
    input  word_t                iss_imm,
    input  logic [TAG_WIDTH-1:0] iss_tag,
    input  logic                 grant,
    output logic                 res_valid,
    output logic [TAG_WIDTH-1:0] res_tag,
    output word_t                res_value,
    output logic                 busy
);

    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    word_t dmem [DMEM_DEPTH];

    // Address stage
    logic                 s1_valid;
    logic                 s1_store;
    logic [ADDR_W-1:0]    s1_addr;
    word_t                s1_data;
    logic [TAG_WIDTH-1:0] s1_tag;

    // Whole pipe stalls while a load result waits for the bus
    assign busy = res_valid && !grant;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            res_valid <= 1'b0;
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (!busy) begin
            s1_valid <= lsu_issue;
            res_valid <= s1_valid && !s1_store;
            if (s1_valid && s1_store) begin
                dmem[s1_addr] <= s1_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            if (lsu_issue) begin
                s1_store <= (iss_op == op_store);
                s1_addr <= iss_a[ADDR_W-1:0] + iss_imm[ADDR_W-1:0];
                s1_data <= iss_b;
                s1_tag <= iss_tag;
            end
            if (s1_valid && !s1_store) begin
                res_tag <= s1_tag;
                res_value <= dmem[s1_addr];
            end
        end
    end

    // Station sees busy before it selects a memory instruction
    a_no_issue_busy: assert property (@(posedge clk) disable iff (reset)
        lsu_issue |-> !busy);

endmodule

//--- rtl/phys_reg_file.sv
`timescale 1ns/10ps

module phys_reg_file import issue_pkg::*; #(
    parameter int PREG_COUNT = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [TAG_WIDTH-1:0] rd_tag_a,
    input  logic [TAG_WIDTH-1:0] rd_tag_b,
    input  logic                 alloc_valid,
    input  logic [TAG_WIDTH-1:0] alloc_tag,
    output word_t                val_a,
    output word_t                val_b,
    output logic                 rdy_a,
    output logic                 rdy_b,
    input  logic                 cdb_valid,
    input  logic [TAG_WIDTH-1:0] cdb_tag,
    input  word_t                cdb_value
);

    word_t value [PREG_COUNT];
    logic [PREG_COUNT-1:0] ready;

    logic hit_a;
    logic hit_b;

    // Same-cycle broadcast is forwarded to the dispatch reads
    assign hit_a = cdb_valid && (cdb_tag == rd_tag_a);
    assign hit_b = cdb_valid && (cdb_tag == rd_tag_b);

    assign val_a = hit_a ? cdb_value : value[rd_tag_a];
    assign val_b = hit_b ? cdb_value : value[rd_tag_b];
    assign rdy_a = hit_a || ready[rd_tag_a];
    assign rdy_b = hit_b || ready[rd_tag_b];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Register i starts out holding i
            for (int i = 0; i < PREG_COUNT; i++) begin
                value[i] <= word_t'(i);
                ready[i] <= 1'b1;
            end
        end else begin
            if (cdb_valid) begin
                value[cdb_tag] <= cdb_value;
                ready[cdb_tag] <= 1'b1;
            end
            // New producer makes its destination pending
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
        end
    end

    // A result only comes back for a tag that was allocated
    a_cdb_pending: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> !ready[cdb_tag]);

endmodule

//--- rtl/reservation_station.sv
`timescale 1ns/10ps

module reservation_station import issue_pkg::*; #(
    parameter int RS_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  op_t                  dispatch_op,
    input  logic [TAG_WIDTH-1:0] dispatch_rs1,
    input  logic [TAG_WIDTH-1:0] dispatch_rs2,
    input  logic [TAG_WIDTH-1:0] dispatch_rd,
    input  word_t                dispatch_imm,
    output logic                 rs_full,
    output logic [TAG_WIDTH-1:0] rd_tag_a,
    output logic [TAG_WIDTH-1:0] rd_tag_b,
    output logic                 alloc_valid,
    output logic [TAG_WIDTH-1:0] alloc_tag,
    input  word_t                val_a,
    input  word_t                val_b,
    input  logic                 rdy_a,
    input  logic                 rdy_b,
    input  logic                 alu_busy,
    input  logic                 lsu_busy,
    output logic                 alu_issue,
    output logic                 lsu_issue,
    output op_t                  iss_op,
    output word_t                iss_a,
    output word_t                iss_b,
    output word_t                iss_imm,
    output logic [TAG_WIDTH-1:0] iss_tag,
    input  logic                 cdb_valid,
    input  logic [TAG_WIDTH-1:0] cdb_tag,
    input  word_t                cdb_value
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    // Slot table
    logic [RS_DEPTH-1:0]  s_valid;
    logic [RS_DEPTH-1:0]  s_rdy1;
    logic [RS_DEPTH-1:0]  s_rdy2;
    op_t                  s_op   [RS_DEPTH];
    logic [TAG_WIDTH-1:0] s_tag1 [RS_DEPTH];
    logic [TAG_WIDTH-1:0] s_tag2 [RS_DEPTH];
    logic [TAG_WIDTH-1:0] s_rd   [RS_DEPTH];
    word_t                s_val1 [RS_DEPTH];
    word_t                s_val2 [RS_DEPTH];
    word_t                s_imm  [RS_DEPTH];
    // Age is the number of younger valid slots
    logic [IDX_W-1:0]     s_age  [RS_DEPTH];

    logic                 accept;
    logic [IDX_W-1:0]     free_idx;
    logic                 mem_found;
    logic [IDX_W-1:0]     mem_age;
    logic [RS_DEPTH-1:0]  eligible;
    logic                 pick_found;
    logic [IDX_W-1:0]     pick_idx;
    logic [IDX_W-1:0]     pick_age;
    logic [RS_DEPTH-1:0]  valid_nxt;
    logic                 age_clash;

    assign accept = dispatch_valid && !rs_full;

    assign rd_tag_a    = dispatch_rs1;
    assign rd_tag_b    = dispatch_rs2;
    assign alloc_valid = accept && writes_rd(dispatch_op);
    assign alloc_tag   = dispatch_rd;

    // Lowest empty slot takes the next dispatch
    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!s_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // Age of the oldest memory instruction held
    always_comb begin
        mem_found = 1'b0;
        mem_age = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (s_valid[i] && is_mem_op(s_op[i]) && (!mem_found || s_age[i] > mem_age)) begin
                mem_found = 1'b1;
                mem_age = s_age[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (is_mem_op(s_op[i])) begin
                eligible[i] = s_valid[i] && s_rdy1[i] && s_rdy2[i] && !lsu_busy &&
                              (s_age[i] == mem_age);
            end else begin
                eligible[i] = s_valid[i] && s_rdy1[i] && s_rdy2[i] && !alu_busy;
            end
        end
    end

    // Oldest eligible slot wins
    always_comb begin
        pick_found = 1'b0;
        pick_idx = '0;
        pick_age = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (eligible[i] && (!pick_found || s_age[i] > pick_age)) begin
                pick_found = 1'b1;
                pick_idx = IDX_W'(i);
                pick_age = s_age[i];
            end
        end
    end

    assign alu_issue = pick_found && !is_mem_op(s_op[pick_idx]);
    assign lsu_issue = pick_found && is_mem_op(s_op[pick_idx]);
    assign iss_op    = s_op[pick_idx];
    assign iss_a     = s_val1[pick_idx];
    assign iss_b     = s_val2[pick_idx];
    assign iss_imm   = s_imm[pick_idx];
    assign iss_tag   = s_rd[pick_idx];

    always_comb begin
        valid_nxt = s_valid;
        if (pick_found) begin
            valid_nxt[pick_idx] = 1'b0;
        end
        if (accept) begin
            valid_nxt[free_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_valid <= '0;
            s_rdy1 <= '0;
            s_rdy2 <= '0;
            rs_full <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                s_age[i] <= '0;
            end
        end else begin
            s_valid <= valid_nxt;
            rs_full <= &valid_nxt;
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (accept && free_idx == IDX_W'(i)) begin
                    s_op[i] <= dispatch_op;
                    s_tag1[i] <= dispatch_rs1;
                    s_tag2[i] <= dispatch_rs2;
                    s_rd[i] <= dispatch_rd;
                    s_imm[i] <= dispatch_imm;
                    s_val1[i] <= val_a;
                    s_val2[i] <= val_b;
                    s_rdy1[i] <= rdy_a;
                    s_rdy2[i] <= rdy_b || !uses_rs2(dispatch_op);
                    s_age[i] <= '0;
                end else begin
                    // Wakeup checks each source on its own
                    if (cdb_valid && !s_rdy1[i] && s_tag1[i] == cdb_tag) begin
                        s_rdy1[i] <= 1'b1;
                        s_val1[i] <= cdb_value;
                    end
                    if (cdb_valid && !s_rdy2[i] && s_tag2[i] == cdb_tag) begin
                        s_rdy2[i] <= 1'b1;
                        s_val2[i] <= cdb_value;
                    end
                    if (s_valid[i] && accept && !(pick_found && s_age[i] > pick_age)) begin
                        s_age[i] <= s_age[i] + 1'b1;
                    end else if (s_valid[i] && !accept && pick_found && s_age[i] > pick_age) begin
                        s_age[i] <= s_age[i] - 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        age_clash = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int j = i + 1; j < RS_DEPTH; j++) begin
                if (s_valid[i] && s_valid[j] && s_age[i] == s_age[j]) begin
                    age_clash = 1'b1;
                end
            end
        end
    end

    // A dispatch is only taken into an empty slot
    a_no_accept_full: assert property (@(posedge clk) disable iff (reset)
        accept |-> !s_valid[free_idx]);

    // Issued slot is empty after the edge
    a_issue_clears: assert property (@(posedge clk) disable iff (reset)
        pick_found |=> !s_valid[$past(pick_idx)]);

    a_unique_age: assert property (@(posedge clk) disable iff (reset) !age_clash);

endmodule

//--- tb.f
rtl/issue_pkg.sv
rtl/phys_reg_file.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/load_store_unit.sv
rtl/cdb_arbiter.sv
rtl/issue_top.sv
testbench/issue_checker.sv
testbench/tb_issue.sv

//--- testbench/issue_checker.sv
`timescale 1ns/10ps

module issue_checker import issue_pkg::*; #(
    parameter int RS_DEPTH   = 4,
    parameter int PREG_COUNT = 32,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  op_t                  dispatch_op,
    input  logic [TAG_WIDTH-1:0] dispatch_rs1,
    input  logic [TAG_WIDTH-1:0] dispatch_rs2,
    input  logic [TAG_WIDTH-1:0] dispatch_rd,
    input  word_t                dispatch_imm,
    input  logic                 rs_full,
    input  logic                 cdb_valid,
    input  logic [TAG_WIDTH-1:0] cdb_tag,
    input  word_t                cdb_value,
    input  logic                 end_check,
    output int                   error_count,
    output int                   check_count
);

    // Program-order model
    word_t                 model_val  [PREG_COUNT];
    word_t                 model_mem  [DMEM_DEPTH];
    logic [PREG_COUNT-1:0] pending;
    logic [PREG_COUNT-1:0] is_load;
    int                    in_flight;
    logic                  seen_dispatch;
    logic                  full_seen;
    logic                  end_done;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    function automatic word_t alu_model(op_t op, word_t a, word_t b, word_t imm);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + imm;
            default: return '0;
        endcase
    endfunction

    // Word address wraps over the memory size
    function automatic int mem_addr(word_t base, word_t imm);
        word_t sum;
        sum = base + imm;
        return int'(sum % DMEM_DEPTH);
    endfunction

    task automatic check_result();
        string name;
        check_count++;
        if (!pending[cdb_tag]) begin
            error_count++;
            $display("CDB carried tag %0d at %0t, but no result was outstanding for it",
                     cdb_tag, $time);
        end else begin
            pending[cdb_tag] = 1'b0;
            in_flight--;
            name = is_load[cdb_tag] ? "load result" : "alu result";
            if (cdb_value !== model_val[cdb_tag]) begin
                error_count++;
                $display("Error %s tag %0d: expected %h, actual %h",
                         name, cdb_tag, model_val[cdb_tag], cdb_value);
            end
        end
    endtask

    task automatic take_dispatch();
        word_t a;
        word_t b;
        word_t res;
        int    addr;
        a = model_val[dispatch_rs1];
        b = model_val[dispatch_rs2];
        addr = mem_addr(a, dispatch_imm);
        if (dispatch_op == op_store) begin
            model_mem[addr] = b;
        end else begin
            if (pending[dispatch_rd]) begin
                error_count++;
                $display("Tag %0d was dispatched again before its result came back",
                         dispatch_rd);
            end
            res = (dispatch_op == op_load) ? model_mem[addr]
                                           : alu_model(dispatch_op, a, b, dispatch_imm);
            model_val[dispatch_rd] = res;
            pending[dispatch_rd] = 1'b1;
            is_load[dispatch_rd] = (dispatch_op == op_load);
            in_flight++;
        end
    endtask

    task automatic final_check();
        end_done = 1'b1;
        check_count++;
        if (!full_seen) begin
            error_count++;
            $display("rs_full never went high during the back-to-back dispatch bursts");
        end
        for (int t = 0; t < PREG_COUNT; t++) begin
            if (pending[t]) begin
                error_count++;
                $display("Tag %0d never completed on the CDB", t);
            end
        end
    endtask

    // Mid-cycle sampling sees the values the next rising edge acts on
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                model_val[i] = word_t'(i);
            end
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                model_mem[i] = '0;
            end
            pending = '0;
            is_load = '0;
            in_flight = 0;
            seen_dispatch = 1'b0;
            full_seen = 1'b0;
            end_done = 1'b0;
        end else begin
            if (!seen_dispatch) begin
                check_count++;
                if (rs_full !== 1'b0 || cdb_valid !== 1'b0) begin
                    error_count++;
                    $display("Error reset state: expected rs_full 0 cdb_valid 0, actual %b %b",
                             rs_full, cdb_valid);
                end
            end
            if (rs_full === 1'b1) begin
                full_seen = 1'b1;
            end
            if (cdb_valid === 1'b1) begin
                check_result();
            end
            if (dispatch_valid) begin
                seen_dispatch = 1'b1;
            end
            if (dispatch_valid && rs_full === 1'b0) begin
                take_dispatch();
            end
            // Station slots plus ALU result, LSU address stage and LSU result
            if (in_flight > RS_DEPTH + 3) begin
                error_count++;
                $display("%0d results outstanding, more than the station and units hold",
                         in_flight);
            end
            if (end_check && !end_done) begin
                final_check();
            end
        end
    end

endmodule

//--- testbench/tb_issue.sv
`timescale 1ns/10ps

module tb_issue import issue_pkg::*; ();

    localparam int RS_DEPTH = 4;
    localparam int PREG_COUNT = 32;
    localparam int DMEM_DEPTH = 16;
    localparam int ARCH_REGS = 8;
    localparam int RESET_CYCLES = 10;
    localparam int N_ALU = 60;
    localparam int N_MIX = 80;
    localparam int N_BURST = 40;
    localparam int N_TOTAL = N_ALU + N_MIX + N_BURST + DMEM_DEPTH + 1;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 40 + RESET_CYCLES;

    logic                 clk;
    logic                 reset;
    logic                 dispatch_valid;
    op_t                  dispatch_op;
    logic [TAG_WIDTH-1:0] dispatch_rs1;
    logic [TAG_WIDTH-1:0] dispatch_rs2;
    logic [TAG_WIDTH-1:0] dispatch_rd;
    word_t                dispatch_imm;
    logic                 rs_full;
    logic                 cdb_valid;
    logic [TAG_WIDTH-1:0] cdb_tag;
    word_t                cdb_value;
    logic                 end_check;
    int                   error_count;
    int                   check_count;

    // Rename state held by the testbench
    logic [31:0]           lfsr;
    logic [TAG_WIDTH-1:0]  arch_map [ARCH_REGS];
    logic [TAG_WIDTH-1:0]  free_q [$];
    logic [PREG_COUNT-1:0] waiting;
    logic [PREG_COUNT-1:0] unmapped;
    int                    last_arch;
    logic [TAG_WIDTH-1:0]  zero_tag;
    logic [TAG_WIDTH-1:0]  load_tag;
    logic [TAG_WIDTH-1:0]  zero_src;

    issue_top #(.RS_DEPTH(RS_DEPTH), .PREG_COUNT(PREG_COUNT), .DMEM_DEPTH(DMEM_DEPTH)) DUT (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_rs1(dispatch_rs1), .dispatch_rs2(dispatch_rs2),
        .dispatch_rd(dispatch_rd), .dispatch_imm(dispatch_imm),
        .rs_full(rs_full),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    issue_checker #(
        .RS_DEPTH(RS_DEPTH), .PREG_COUNT(PREG_COUNT), .DMEM_DEPTH(DMEM_DEPTH)
    ) u_checker (
        .clk(clk), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_rs1(dispatch_rs1), .dispatch_rs2(dispatch_rs2),
        .dispatch_rd(dispatch_rd), .dispatch_imm(dispatch_imm),
        .rs_full(rs_full),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .end_check(end_check), .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Results seen on the bus release tags that are no longer mapped
    always @(negedge clk) begin
        if (!reset) begin
            if (cdb_valid) begin
                waiting[cdb_tag] = 1'b0;
            end
            for (int t = 0; t < PREG_COUNT; t++) begin
                if (unmapped[t] && !waiting[t]) begin
                    unmapped[t] = 1'b0;
                    free_q.push_back(TAG_WIDTH'(t));
                end
            end
        end
    end

    task automatic rename_dest(input int arch, output logic [TAG_WIDTH-1:0] tag);
        while (free_q.size() == 0) begin
            @(posedge clk);
            #1;
        end
        tag = free_q.pop_front();
        waiting[tag] = 1'b1;
        unmapped[arch_map[arch]] = 1'b1;
        arch_map[arch] = tag;
        last_arch = arch;
    endtask

    // Holds the instruction on the port until the station takes it
    task automatic send_instr(input op_t op, input logic [TAG_WIDTH-1:0] rs1,
                              input logic [TAG_WIDTH-1:0] rs2,
                              input logic [TAG_WIDTH-1:0] rd, input word_t imm);
        logic taken;
        dispatch_valid = 1'b1;
        dispatch_op = op;
        dispatch_rs1 = rs1;
        dispatch_rs2 = rs2;
        dispatch_rd = rd;
        dispatch_imm = imm;
        do begin
            taken = !rs_full;
            @(posedge clk);
            #1;
        end while (!taken);
        dispatch_valid = 1'b0;
    endtask

    task automatic random_instr(input logic mem_mix);
        op_t                  op;
        int                   a1;
        int                   a2;
        logic [TAG_WIDTH-1:0] rs1;
        logic [TAG_WIDTH-1:0] rs2;
        logic [TAG_WIDTH-1:0] rd;
        word_t                imm;
        if (mem_mix && take_bits(1)) begin
            op = take_bits(1) ? op_store : op_load;
        end else begin
            op = op_t'(3'(take_bits(3) % 6));
        end
        // Half the time read the latest result to build chains
        a1 = take_bits(1) ? last_arch : int'(take_bits(3) % ARCH_REGS);
        a2 = int'(take_bits(3) % ARCH_REGS);
        rs1 = arch_map[a1];
        rs2 = arch_map[a2];
        imm = take_bits(32);
        rd = '0;
        if (op != op_store) begin
            rename_dest(int'(take_bits(3) % ARCH_REGS), rd);
        end
        send_instr(op, rs1, rs2, rd, imm);
    endtask

    task automatic random_gap();
        if (take_bits(2) == 0) begin
            repeat (1 + take_bits(2)) @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (waiting != '0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with results still missing", WATCHDOG_CYCLES);
        for (int t = 0; t < PREG_COUNT; t++) begin
            if (waiting[t]) begin
                $display("Tag %0d was allocated but never completed on the CDB", t);
            end
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        lfsr = 32'ha20a_d967;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_rd = '0;
        dispatch_imm = '0;
        end_check = 1'b0;
        waiting = '0;
        unmapped = '0;
        last_arch = 0;
        // Tags 0..7 keep their reset values as the first architectural state
        for (int a = 0; a < ARCH_REGS; a++) begin
            arch_map[a] = TAG_WIDTH'(a);
        end
        for (int t = ARCH_REGS; t < PREG_COUNT; t++) begin
            free_q.push_back(TAG_WIDTH'(t));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        repeat (N_ALU) begin
            random_instr(1'b0);
            random_gap();
        end
        repeat (N_MIX) begin
            random_instr(1'b1);
            random_gap();
        end
        // No gaps, so the station fills up
        repeat (N_BURST) begin
            random_instr(1'b1);
        end
        wait_drain();

        // Zero base for one load per address
        zero_src = arch_map[0];
        rename_dest(0, zero_tag);
        send_instr(op_xor, zero_src, zero_src, zero_tag, '0);
        for (int a = 0; a < DMEM_DEPTH; a++) begin
            rename_dest(1 + a % (ARCH_REGS - 1), load_tag);
            send_instr(op_load, zero_tag, zero_tag, load_tag, word_t'(a));
        end
        wait_drain();

        end_check = 1'b1;
        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
